// File: adc_spi_capture.f
+incdir+include
logic/adc_types_pkg.sv
logic/apb_pkg.sv
logic/sclk_gen.sv
logic/adc_sequencer.sv
logic/adc_apb_regs.sv
logic/adc_top.sv
verification/adc_model.sv
verification/adc_assertions.sv
verification/adc_tb.sv

// File: Bender.yml
package:
  name: adc_spi_capture

sources:
  - include_dirs:
      - include
    files:
      - logic/adc_types_pkg.sv
      - logic/apb_pkg.sv
      - logic/sclk_gen.sv
      - logic/adc_sequencer.sv
      - logic/adc_apb_regs.sv
      - logic/adc_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - verification/adc_model.sv
      - verification/adc_assertions.sv
      - verification/adc_tb.sv

// File: verification/adc_tb.sv
`timescale 1ns/1ps
`include "adc_consts.svh"

module adc_tb;

    import apb_pkg::*;

    logic        clk = 1'b0;
    logic        reset;
    apb_req_t    req;
    apb_rsp_t    rsp;
    logic        cs;
    logic        sclk;
    logic        sdo;
    logic [11:0] adc_value;
    logic [31:0] rdata;
    logic        slverr;
    logic [31:0] saved_count;
    int          seed = 83338;
    int          errors = 0;
    int          test_start = 0;
    int          passed = 0;
    int          failed = 0;

    always #10 clk = ~clk;

    adc_top dut (
        .clk     (clk),
        .reset   (reset),
        .apb_req (req),
        .apb_rsp (rsp),
        .cs      (cs),
        .sclk    (sclk),
        .sdo     (sdo)
    );

    adc_model model (
        .cs    (cs),
        .sclk  (sclk),
        .value (adc_value),
        .sdo   (sdo)
    );

    function automatic int error_total();
        return errors + dut.u_assert.fails;
    endfunction

    task automatic apb_xfer(input logic write, input logic [7:0] addr, input logic [31:0] wdata);
        @(posedge clk);
        req <= '{psel: 1'b1, penable: 1'b0, pwrite: write, paddr: addr, pwdata: wdata};
        @(posedge clk);
        req.penable <= 1'b1;
        @(negedge clk);  // middle of the access cycle
        rdata  = rsp.prdata;
        slverr = rsp.pslverr;
        @(posedge clk);
        req <= '0;
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("ERROR %s expected %0h actual %0h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic wait_for_reg(input string name, input logic [7:0] addr,
                                input logic [31:0] mask, input logic [31:0] value);
        int tries;
        for (tries = 0; tries < 300; tries++) begin
            apb_xfer(1'b0, addr, '0);
            if ((rdata & mask) == value) break;
        end
        if (tries == 300) begin
            $display("%s: register %0h never reached the expected value", name, addr);
            errors++;
        end
    endtask

    task automatic convert_and_check(input string name, input logic [11:0] value);
        @(posedge clk);
        adc_value <= value;
        apb_xfer(1'b1, `ADC_REG_CTRL, 32'h1);
        wait_for_reg(name, `ADC_REG_STATUS, 32'h4, 32'h4);  // data_valid
        apb_xfer(1'b0, `ADC_REG_DATA, '0);
        check_value(name, {20'b0, value}, rdata);
    endtask

    task automatic finish_test(input string name);
        if (error_total() == test_start) begin
            $display("%s: passed", name);
            passed++;
        end else begin
            $display("%s: failed", name);
            failed++;
        end
        test_start = error_total();
    endtask

    initial begin
        req       = '0;
        reset     = 1'b1;
        adc_value = '0;
        repeat (5) @(posedge clk);
        reset <= 1'b0;

        apb_xfer(1'b0, `ADC_REG_STATUS, '0);
        check_value("reset_calibration", 32'h1, rdata & 32'h3);  // busy, not calibrated
        wait_for_reg("reset_calibration", `ADC_REG_STATUS, 32'h3, 32'h2);
        finish_test("reset_calibration");

        convert_and_check("single_conversion", 12'hA5C);
        apb_xfer(1'b0, `ADC_REG_STATUS, '0);
        check_value("single_conversion", 32'h0, rdata & 32'h4);
        apb_xfer(1'b0, `ADC_REG_COUNT, '0);
        check_value("single_conversion", 32'd1, rdata);
        finish_test("single_conversion");

        repeat (8) convert_and_check("random_values", 12'($random(seed)));
        apb_xfer(1'b0, `ADC_REG_COUNT, '0);
        check_value("random_values", 32'd9, rdata);
        finish_test("random_values");

        @(posedge clk);
        adc_value <= 12'h3C7;
        apb_xfer(1'b1, `ADC_REG_CTRL, 32'h4);
        wait_for_reg("continuous_overrun", `ADC_REG_COUNT, 32'hFFFF, 32'd11);
        apb_xfer(1'b0, `ADC_REG_STATUS, '0);
        check_value("continuous_overrun", 32'h8, rdata & 32'h8);
        apb_xfer(1'b1, `ADC_REG_CTRL, 32'h0);
        wait_for_reg("continuous_overrun", `ADC_REG_STATUS, 32'h1, 32'h0);
        apb_xfer(1'b0, `ADC_REG_DATA, '0);
        check_value("continuous_overrun", 32'h3C7, rdata);
        apb_xfer(1'b1, `ADC_REG_STATUS, 32'h8);
        apb_xfer(1'b0, `ADC_REG_STATUS, '0);
        check_value("continuous_overrun", 32'h0, rdata & 32'h8);
        finish_test("continuous_overrun");

        apb_xfer(1'b1, `ADC_REG_CTRL, 32'h2);
        apb_xfer(1'b0, `ADC_REG_STATUS, '0);
        check_value("recalibration", 32'h1, rdata & 32'h3);
        wait_for_reg("recalibration", `ADC_REG_STATUS, 32'h3, 32'h2);
        convert_and_check("recalibration", 12'h5A3);
        finish_test("recalibration");

        apb_xfer(1'b0, `ADC_REG_COUNT, '0);
        saved_count = rdata;
        apb_xfer(1'b0, 8'h10, '0);
        check_value("unmapped_address", 32'h1, {31'b0, slverr});
        check_value("unmapped_address", 32'h0, rdata);
        apb_xfer(1'b1, 8'h10, 32'h7);
        check_value("unmapped_address", 32'h1, {31'b0, slverr});
        apb_xfer(1'b0, `ADC_REG_CTRL, '0);
        check_value("unmapped_address", 32'h0, rdata);
        apb_xfer(1'b0, `ADC_REG_DATA, '0);
        check_value("unmapped_address", 32'h5A3, rdata);
        apb_xfer(1'b0, `ADC_REG_COUNT, '0);
        check_value("unmapped_address", saved_count, rdata);
        finish_test("unmapped_address");

        $display("tests passed %0d, failed %0d, errors %0d", passed, failed, error_total());
        if (error_total() == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// File: verification/adc_assertions.sv
`timescale 1ns/1ps
`include "adc_consts.svh"

module adc_assertions (
    input logic              clk,
    input logic              reset,
    input logic              cs,
    input logic              sclk,
    input apb_pkg::apb_req_t apb_req,
    input apb_pkg::apb_rsp_t apb_rsp
);

    logic       sclk_q;
    logic [5:0] rises;  // sclk rises in the current cs low phase
    int         fails = 0;

    always_ff @(posedge clk) begin
        sclk_q <= sclk;
        if (reset || cs) begin
            rises <= '0;
        end else if (sclk && !sclk_q) begin
            rises <= rises + 1'b1;
        end
    end

    sclk_idle_high: assert property (@(posedge clk) disable iff (reset) cs |-> sclk)
        else begin
            $error("sclk low while cs high");
            fails++;
        end

    pready_high: assert property (@(posedge clk) disable iff (reset)
        apb_req.psel && apb_req.penable |-> apb_rsp.pready)
        else begin
            $error("apb access completed without pready");
            fails++;
        end

    rises_per_frame: assert property (@(posedge clk) disable iff (reset)
        $rose(cs) |-> (rises == `ADC_FRAME_BITS || rises == `ADC_CAL_BITS))
        else begin
            $error("cs low phase held %0d sclk rises", $sampled(rises));
            fails++;
        end

    cs_high_after_reset: assert property (@(posedge clk) $fell(reset) |-> cs ##1 !cs)
        else begin
            $error("cs not high until calibration begins");
            fails++;
        end

endmodule

bind adc_top adc_assertions u_assert (
    .clk     (clk),
    .reset   (reset),
    .cs      (cs),
    .sclk    (sclk),
    .apb_req (apb_req),
    .apb_rsp (apb_rsp)
);

// File: verification/adc_model.sv
`timescale 1ns/1ps
`include "adc_consts.svh"

module adc_model (
    input  logic                      cs,
    input  logic                      sclk,
    input  logic [`ADC_DATA_BITS-1:0] value,
    output logic                      sdo
);

    logic [`ADC_FRAME_BITS-1:0] frame = '0;
    logic                       first_fall = 1'b0;

    assign sdo = frame[`ADC_FRAME_BITS-1];

    // sclk idles high, so a cs fall is seen with sclk still high
    always @(negedge cs or negedge sclk) begin
        if (sclk) begin
            frame      <= {{`ADC_LEAD_BITS{1'b0}}, value};  // first lead bit out
            first_fall <= 1'b1;
        end else if (!cs) begin
            if (first_fall) begin
                first_fall <= 1'b0;  // opening fall keeps bit 0 of the frame
            end else begin
                frame <= {frame[`ADC_FRAME_BITS-2:0], 1'b0};
            end
        end
    end

endmodule

// File: logic/adc_top.sv
`timescale 1ns/1ps
`include "adc_consts.svh"

module adc_top #(
    parameter int SCLK_DIV = `ADC_SCLK_DIV
) (
    input  logic              clk,
    input  logic              reset,
    input  apb_pkg::apb_req_t apb_req,
    output apb_pkg::apb_rsp_t apb_rsp,
    output logic              cs,
    output logic              sclk,
    input  logic              sdo
);

    import adc_types_pkg::*;

    adc_cmd_t    cmd;
    adc_status_t status;
    adc_sample_t sample;
    logic        run;
    logic        sclk_rise;

    adc_apb_regs u_regs (
        .clk    (clk),
        .reset  (reset),
        .req    (apb_req),
        .rsp    (apb_rsp),
        .status (status),
        .sample (sample),
        .cmd    (cmd)
    );

    adc_sequencer u_seq (
        .clk       (clk),
        .reset     (reset),
        .cmd       (cmd),
        .sclk_rise (sclk_rise),
        .sdo       (sdo),
        .run       (run),
        .cs        (cs),
        .status    (status),
        .sample    (sample)
    );

    sclk_gen #(.SCLK_DIV(SCLK_DIV)) u_sclk (
        .clk       (clk),
        .reset     (reset),
        .run       (run),
        .sclk      (sclk),
        .sclk_rise (sclk_rise),
        .sclk_fall ()
    );

endmodule

// File: logic/adc_apb_regs.sv
`timescale 1ns/1ps
`include "adc_consts.svh"

module adc_apb_regs (
    input  logic                       clk,
    input  logic                       reset,
    input  apb_pkg::apb_req_t          req,
    output apb_pkg::apb_rsp_t          rsp,
    input  adc_types_pkg::adc_status_t status,
    input  adc_types_pkg::adc_sample_t sample,
    output adc_types_pkg::adc_cmd_t    cmd
);

    logic                      access;
    logic                      addr_ok;
    logic                      wr_ctrl;
    logic                      wr_status;
    logic                      rd_data;
    logic                      data_valid;
    logic                      overrun;
    logic [`ADC_DATA_BITS-1:0] data_reg;
    logic [15:0]               count;

    assign access  = req.psel && req.penable;  // access phase
    assign addr_ok = (req.paddr == `ADC_REG_CTRL) || (req.paddr == `ADC_REG_STATUS) ||
                     (req.paddr == `ADC_REG_DATA) || (req.paddr == `ADC_REG_COUNT);

    assign wr_ctrl   = access && req.pwrite && (req.paddr == `ADC_REG_CTRL);
    assign wr_status = access && req.pwrite && (req.paddr == `ADC_REG_STATUS);
    assign rd_data   = access && !req.pwrite && (req.paddr == `ADC_REG_DATA);

    always_ff @(posedge clk) begin
        if (reset) begin
            cmd        <= '0;
            data_valid <= 1'b0;
            overrun    <= 1'b0;
            count      <= '0;
        end else begin
            cmd.start <= wr_ctrl && req.pwdata[0];
            cmd.recal <= wr_ctrl && req.pwdata[1];
            if (wr_ctrl) begin
                cmd.continuous <= req.pwdata[2];
            end

            // a new sample beats a read in the same cycle
            if (sample.valid) begin
                data_valid <= 1'b1;
                count      <= count + 1'b1;
            end else if (rd_data) begin
                data_valid <= 1'b0;
            end

            if (sample.valid && data_valid) begin
                overrun <= 1'b1;  // unread sample overwritten
            end else if (wr_status && req.pwdata[3]) begin
                overrun <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (sample.valid) begin
            data_reg <= sample.data;
        end
    end

    always_comb begin
        case (req.paddr)
            `ADC_REG_CTRL:   rsp.prdata = {29'b0, cmd.continuous, 2'b0};
            `ADC_REG_STATUS: rsp.prdata = {28'b0, overrun, data_valid,
                                           status.calibrated, status.busy};
            `ADC_REG_DATA:   rsp.prdata = {{(32 - `ADC_DATA_BITS){1'b0}}, data_reg};
            `ADC_REG_COUNT:  rsp.prdata = {16'b0, count};
            default:         rsp.prdata = '0;
        endcase
    end

    assign rsp.pready  = 1'b1;
    assign rsp.pslverr = access && !addr_ok;

endmodule

// File: logic/adc_sequencer.sv
`timescale 1ns/1ps
`include "adc_consts.svh"

module adc_sequencer (
    input  logic                      clk,
    input  logic                      reset,
    input  adc_types_pkg::adc_cmd_t   cmd,
    input  logic                      sclk_rise,
    input  logic                      sdo,
    output logic                      run,
    output logic                      cs,
    output adc_types_pkg::adc_status_t status,
    output adc_types_pkg::adc_sample_t sample
);

    import adc_types_pkg::*;

    localparam int CNT_W = $clog2(`ADC_CAL_BITS);
    localparam logic [CNT_W-1:0] CAL_LAST   = CNT_W'(`ADC_CAL_BITS - 1);
    localparam logic [CNT_W-1:0] FRAME_LAST = CNT_W'(`ADC_FRAME_BITS - 1);
    localparam logic [CNT_W-1:0] LEAD_BITS  = CNT_W'(`ADC_LEAD_BITS);

    adc_state_e                state;
    logic [CNT_W-1:0]          bit_cnt;   // shared by calibration and conversion
    logic [`ADC_DATA_BITS-1:0] shift_reg;
    logic                      calibrated;
    logic                      sample_valid;

    always_ff @(posedge clk) begin
        if (reset) begin
            state        <= INIT;
            bit_cnt      <= '0;
            cs           <= 1'b1;
            run          <= 1'b0;
            calibrated   <= 1'b0;
            sample_valid <= 1'b0;
        end else begin
            sample_valid <= 1'b0;
            case (state)
                INIT: begin
                    bit_cnt <= '0;
                    cs      <= 1'b0;
                    run     <= 1'b1;
                    state   <= CALIBRATE;
                end

                CALIBRATE: begin
                    if (sclk_rise) begin
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == CAL_LAST) begin
                            cs         <= 1'b1;
                            run        <= 1'b0;
                            calibrated <= 1'b1;
                            state      <= IDLE;
                        end
                    end
                end

                IDLE: begin
                    bit_cnt <= '0;
                    if (cmd.recal) begin  // recal wins over start
                        calibrated <= 1'b0;
                        cs         <= 1'b0;
                        run        <= 1'b1;
                        state      <= CALIBRATE;
                    end else if (cmd.start || cmd.continuous) begin
                        cs    <= 1'b0;
                        run   <= 1'b1;
                        state <= RECEIVE;
                    end
                end

                RECEIVE: begin
                    if (sclk_rise) begin
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == FRAME_LAST) begin
                            sample_valid <= 1'b1;
                            cs           <= 1'b1;
                            run          <= 1'b0;
                            state        <= IDLE;
                        end
                    end
                end

                default: state <= INIT;
            endcase
        end
    end

    // lead bits are skipped, data comes msb first
    always_ff @(posedge clk) begin
        if (state == RECEIVE && sclk_rise && bit_cnt >= LEAD_BITS) begin
            shift_reg <= {shift_reg[`ADC_DATA_BITS-2:0], sdo};
        end
    end

    assign status.busy       = (state != IDLE);
    assign status.calibrated = calibrated;
    assign sample.valid      = sample_valid;
    assign sample.data       = shift_reg;  // complete when valid is high

endmodule

// File: logic/sclk_gen.sv
`timescale 1ns/1ps
`include "adc_consts.svh"

module sclk_gen #(
    parameter int SCLK_DIV = `ADC_SCLK_DIV
) (
    input  logic clk,
    input  logic reset,
    input  logic run,
    output logic sclk,
    output logic sclk_rise,
    output logic sclk_fall
);

    localparam int HALF = SCLK_DIV / 2;
    localparam int CNT_W = $clog2(HALF + 1);
    localparam logic [CNT_W-1:0] HALF_LAST = CNT_W'(HALF - 1);

    logic [CNT_W-1:0] div_cnt;
    logic             toggle;

    assign toggle = (div_cnt == HALF_LAST);  // end of half period

    always_ff @(posedge clk) begin
        if (reset || !run) begin
            div_cnt   <= '0;
            sclk      <= 1'b1;  // idle high, first edge is a fall
            sclk_rise <= 1'b0;
            sclk_fall <= 1'b0;
        end else begin
            sclk_rise <= toggle && !sclk;
            sclk_fall <= toggle && sclk;
            if (toggle) begin
                div_cnt <= '0;
                sclk    <= ~sclk;
            end else begin
                div_cnt <= div_cnt + 1'b1;
            end
        end
    end

endmodule

// File: logic/apb_pkg.sv
package apb_pkg;

    // host to slave
    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [7:0]  paddr;
        logic [31:0] pwdata;
    } apb_req_t;

    // slave to host
    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;   // tied high, no wait states
        logic        pslverr;
    } apb_rsp_t;

endpackage

// File: logic/adc_types_pkg.sv
`include "adc_consts.svh"

package adc_types_pkg;

    typedef struct packed {
        logic start;       // one cycle pulse
        logic recal;       // one cycle pulse
        logic continuous;  // level
    } adc_cmd_t;

    typedef struct packed {
        logic busy;
        logic calibrated;
    } adc_status_t;

    typedef struct packed {
        logic                      valid;  // one pulse per frame
        logic [`ADC_DATA_BITS-1:0] data;
    } adc_sample_t;

    typedef enum logic [1:0] {
        INIT,
        CALIBRATE,
        IDLE,
        RECEIVE
    } adc_state_e;

endpackage

// File: include/adc_consts.svh
`ifndef ADC_CONSTS_SVH
`define ADC_CONSTS_SVH

// serial frame layout
`define ADC_DATA_BITS   12
`define ADC_LEAD_BITS   2
`define ADC_FRAME_BITS  14
`define ADC_CAL_BITS    32

// clk cycles per sclk period
`define ADC_SCLK_DIV    8

// apb register offsets
`define ADC_REG_CTRL    8'h00
`define ADC_REG_STATUS  8'h04
`define ADC_REG_DATA    8'h08
`define ADC_REG_COUNT   8'h0C

`endif
